//--- hdl/fixedPointPkg.sv
`default_nettype none

package fixedPointPkg;

  // Integer and fraction bits of the signed Q12.12 format
  localparam int intBits = 12;
  localparam int fracBits = 12;

  // Signed Q12.12 for positions, directions and step distances
  typedef logic signed [intBits+fracBits-1:0] fixedT;

  // Unsigned Q12.12 for the track distances
  // A huge step may push a track past the signed range, so compares stay unsigned
  typedef logic [intBits+fracBits-1:0] uFixedT;

  // Full signed product of two fixedT operands
  typedef logic signed [2*(intBits+fracBits)-1:0] wideT;

  // Wall distance as UQ7.9, taken from bits 6 down to -9 of a track
  typedef logic [15:0] distT;

  // Wall half-size, bits 2 down to -8 of the distance reciprocal
  typedef logic [10:0] sizeT;

  // The value 1.0
  localparam fixedT fixedOne = fixedT'(1 << fracBits);

  // Largest positive value, used when a reciprocal overflows
  localparam fixedT fixedMax = {1'b0, {(intBits+fracBits-1){1'b1}}};

endpackage

`default_nettype wire

//--- hdl/tracerPkg.sv
`default_nettype none

package tracerPkg;

  // The map is 16 by 16 cells, so one coordinate is 4 bits
  localparam int mapBits = 4;
  typedef logic [mapBits-1:0] mapCoordT;

  // The top row sits 272 vplane steps above the centre
  // 240 visible lines above the middle, plus the 33-line back porch,
  // less one because each result shows on the following line
  localparam int startRows = 272;

  // The deflection accumulates a whole vplane per row
  // This shift brings it back to the scale of the facing vector
  localparam int addendShift = 8;

  // Step setup runs X then Y through one divider and one multiplier
  typedef enum logic [2:0] {
    setupIdle,
    divX,
    divY,
    mulX,
    mulY
  } setupStateT;

  // The walker tests one cell per cycle while stepping
  typedef enum logic {
    walkIdle,
    walkStep
  } walkStateT;

  // The sizer divides, then holds its result until hmax
  typedef enum logic [1:0] {
    sizerIdle,
    sizerDivide,
    sizerHold
  } sizerStateT;

endpackage

`default_nettype wire

//--- hdl/reciprocal.sv
`default_nettype none

module reciprocal (
  input  wire logic                 clk,
  input  wire logic                 do_reset,
  input  wire logic                 i_start,
  input  wire fixedPointPkg::fixedT i_value,
  output logic                      o_done,
  output fixedPointPkg::fixedT      o_result
);

  fixedPointPkg::uFixedT magnitude;
  fixedPointPkg::uFixedT divisor;
  fixedPointPkg::uFixedT remainder;
  fixedPointPkg::uFixedT quotient;
  logic [24:0]           trial;
  logic [4:0]            bitsLeft;
  logic                  busy;
  logic                  saturate;

  // The sign is dropped, only the magnitude is divided
  assign magnitude = (i_value < 0) ? fixedPointPkg::uFixedT'(-i_value)
                                   : fixedPointPkg::uFixedT'(i_value);

  assign busy = (bitsLeft != 5'd0);

  // Remainder shifted left with the next dividend bit, always zero below bit 24
  assign trial = {remainder, 1'b0};

  // Divider sequencing, one quotient bit per cycle for 24 cycles after the load
  always_ff @(posedge clk) begin
    if (do_reset) begin
      bitsLeft <= 5'd0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start && !busy) begin
        bitsLeft <= 5'd24;
      end else if (busy) begin
        bitsLeft <= bitsLeft - 5'd1;
        // Last quotient bit lands together with the done pulse
        if (bitsLeft == 5'd1) begin
          o_done <= 1'b1;
        end
      end
    end
  end

  // Restoring division of 1.0 shifted up by fracBits, i.e. 2^24 over the magnitude
  always_ff @(posedge clk) begin
    if (i_start && !busy) begin
      divisor <= magnitude;
      // Dividend bit 24 is already brought in here
      // Its quotient bit is only set for magnitudes below 2, which saturate anyway
      remainder <= fixedPointPkg::uFixedT'(1);
      quotient <= '0;
      // A quotient of 2^23 or more does not fit, which covers 0, 1 and 2 LSB
      saturate <= (magnitude <= fixedPointPkg::uFixedT'(2));
    end else if (busy) begin
      if (trial >= {1'b0, divisor}) begin
        remainder <= fixedPointPkg::uFixedT'(trial - {1'b0, divisor});
        quotient <= {quotient[22:0], 1'b1};
      end else begin
        remainder <= fixedPointPkg::uFixedT'(trial);
        quotient <= {quotient[22:0], 1'b0};
      end
    end
  end

  assign o_result = saturate ? fixedPointPkg::fixedMax : fixedPointPkg::fixedT'(quotient);

endmodule

`default_nettype wire

//--- hdl/rayGenerator.sv
`default_nettype none

module rayGenerator (
  input  wire logic                 clk,
  input  wire logic                 do_reset,
  input  wire logic                 i_vsync,
  input  wire logic                 i_present,
  input  wire fixedPointPkg::fixedT i_facingX,
  input  wire fixedPointPkg::fixedT i_facingY,
  input  wire fixedPointPkg::fixedT i_vplaneX,
  input  wire fixedPointPkg::fixedT i_vplaneY,
  output logic                      o_rowStart,
  output fixedPointPkg::fixedT      o_rayDirX,
  output fixedPointPkg::fixedT      o_rayDirY
);

  // Deflection from the facing vector, one whole vplane per row
  fixedPointPkg::fixedT addendX;
  fixedPointPkg::fixedT addendY;
  // Set while the frame is held, so the top row starts once it is released
  logic                 frameStart;

  // Ray direction for the current row
  assign o_rayDirX = i_facingX + (addendX >>> tracerPkg::addendShift);
  assign o_rayDirY = i_facingY + (addendY >>> tracerPkg::addendShift);

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      // Top row of the frame
      addendX <= fixedPointPkg::fixedT'(-(i_vplaneX * tracerPkg::startRows));
      addendY <= fixedPointPkg::fixedT'(-(i_vplaneY * tracerPkg::startRows));
      frameStart <= 1'b1;
      o_rowStart <= 1'b0;
    end else begin
      frameStart <= 1'b0;
      // A new row starts after the frame restart and after each presented result
      o_rowStart <= frameStart || i_present;
      if (i_present) begin
        addendX <= addendX + i_vplaneX;
        addendY <= addendY + i_vplaneY;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/stepSetup.sv
`default_nettype none

module stepSetup (
  input  wire logic                 clk,
  input  wire logic                 do_reset,
  input  wire logic                 i_start,
  input  wire fixedPointPkg::fixedT i_rayDirX,
  input  wire fixedPointPkg::fixedT i_rayDirY,
  input  wire fixedPointPkg::fixedT i_playerX,
  input  wire fixedPointPkg::fixedT i_playerY,
  output logic                      o_done,
  output fixedPointPkg::fixedT      o_stepDistX,
  output fixedPointPkg::fixedT      o_stepDistY,
  output fixedPointPkg::uFixedT     o_trackInitX,
  output fixedPointPkg::uFixedT     o_trackInitY,
  output logic                      o_stepXPositive,
  output logic                      o_stepYPositive
);

  tracerPkg::setupStateT state;
  logic                  recipStart;
  logic                  recipDone;
  fixedPointPkg::fixedT  recipValue;
  fixedPointPkg::fixedT  recipResult;
  fixedPointPkg::fixedT  fracX;
  fixedPointPkg::fixedT  fracY;
  fixedPointPkg::fixedT  partialX;
  fixedPointPkg::fixedT  partialY;
  fixedPointPkg::fixedT  mulA;
  fixedPointPkg::fixedT  mulB;
  fixedPointPkg::wideT   product;

  // X divides first and Y starts in the cycle the X result comes out
  assign recipStart = ((state == tracerPkg::setupIdle) && i_start)
                   || ((state == tracerPkg::divX) && recipDone);
  assign recipValue = (state == tracerPkg::setupIdle) ? i_rayDirX : i_rayDirY;

  // Step distance is the distance along the ray to cross one cell on an axis
  reciprocal stepRecip (
    .clk      (clk),
    .do_reset (do_reset),
    .i_start  (recipStart),
    .i_value  (recipValue),
    .o_done   (recipDone),
    .o_result (recipResult)
  );

  // Player position inside its cell
  assign fracX = fixedPointPkg::fixedT'(i_playerX[fixedPointPkg::fracBits-1:0]);
  assign fracY = fixedPointPkg::fixedT'(i_playerY[fixedPointPkg::fracBits-1:0]);

  // Part of a cell left before the first gridline in the step direction
  // A zero fraction gives a full cell when stepping up and nothing when stepping down
  assign partialX = o_stepXPositive ? fixedPointPkg::fixedOne - fracX : fracX;
  assign partialY = o_stepYPositive ? fixedPointPkg::fixedOne - fracY : fracY;

  // One multiplier shared by the two axes
  assign mulA = (state == tracerPkg::mulX) ? o_stepDistX : o_stepDistY;
  assign mulB = (state == tracerPkg::mulX) ? partialX : partialY;
  assign product = fixedPointPkg::wideT'(mulA) * fixedPointPkg::wideT'(mulB);

  // The sequence idle, divX, mulX, divY, mulY lets X multiply while Y divides
  always_ff @(posedge clk) begin
    if (do_reset) begin
      state <= tracerPkg::setupIdle;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        tracerPkg::setupIdle: if (i_start) state <= tracerPkg::divX;
        tracerPkg::divX:      if (recipDone) state <= tracerPkg::mulX;
        tracerPkg::mulX:      state <= tracerPkg::divY;
        tracerPkg::divY:      if (recipDone) state <= tracerPkg::mulY;
        tracerPkg::mulY: begin
          state <= tracerPkg::setupIdle;
          o_done <= 1'b1;
        end
        default:              state <= tracerPkg::setupIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // The step directions are fixed for the row at its start
    if ((state == tracerPkg::setupIdle) && i_start) begin
      o_stepXPositive <= (i_rayDirX > 0);
      o_stepYPositive <= (i_rayDirY > 0);
    end
    if ((state == tracerPkg::divX) && recipDone) begin
      o_stepDistX <= recipResult;
    end
    if ((state == tracerPkg::divY) && recipDone) begin
      o_stepDistY <= recipResult;
    end
    // Middle 24 bits of the product are back in Q12.12
    if (state == tracerPkg::mulX) begin
      o_trackInitX <= product[2*fixedPointPkg::fracBits+fixedPointPkg::intBits-1:
                              fixedPointPkg::fracBits];
    end
    if (state == tracerPkg::mulY) begin
      o_trackInitY <= product[2*fixedPointPkg::fracBits+fixedPointPkg::intBits-1:
                              fixedPointPkg::fracBits];
    end
  end

endmodule

`default_nettype wire

//--- hdl/gridWalker.sv
`default_nettype none

module gridWalker (
  input  wire logic                  clk,
  input  wire logic                  do_reset,
  input  wire logic                  i_start,
  input  wire fixedPointPkg::fixedT  i_playerX,
  input  wire fixedPointPkg::fixedT  i_playerY,
  input  wire fixedPointPkg::fixedT  i_stepDistX,
  input  wire fixedPointPkg::fixedT  i_stepDistY,
  input  wire fixedPointPkg::uFixedT i_trackInitX,
  input  wire fixedPointPkg::uFixedT i_trackInitY,
  input  wire logic                  i_stepXPositive,
  input  wire logic                  i_stepYPositive,
  input  wire logic                  i_mapVal,
  output tracerPkg::mapCoordT        o_mapCol,
  output tracerPkg::mapCoordT        o_mapRow,
  output logic                       o_done,
  output fixedPointPkg::distT        o_wallDist,
  output logic                       o_hitSide
);

  tracerPkg::walkStateT  state;
  // Ray length to the next X and the next Y gridline
  fixedPointPkg::uFixedT trackX;
  fixedPointPkg::uFixedT trackY;
  logic                  needStepX;

  // The nearer gridline is crossed first and a tie steps along Y
  assign needStepX = (trackX < trackY);

  // The map answers for o_mapCol and o_mapRow in the same cycle
  always_ff @(posedge clk) begin
    if (do_reset) begin
      state <= tracerPkg::walkIdle;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        tracerPkg::walkIdle: if (i_start) state <= tracerPkg::walkStep;
        tracerPkg::walkStep: begin
          if (i_mapVal) begin
            state <= tracerPkg::walkIdle;
            o_done <= 1'b1;
          end
        end
        default: state <= tracerPkg::walkIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == tracerPkg::walkIdle) && i_start) begin
      // The walk begins in the player's own cell
      o_mapCol <= i_playerX[fixedPointPkg::fracBits +: tracerPkg::mapBits];
      o_mapRow <= i_playerY[fixedPointPkg::fracBits +: tracerPkg::mapBits];
      trackX <= i_trackInitX;
      trackY <= i_trackInitY;
      o_wallDist <= '0;
      o_hitSide <= 1'b0;
    end else if ((state == tracerPkg::walkStep) && !i_mapVal) begin
      // The track before the step is the distance to the face of the next cell
      // Bits 6 down to -9 of the track form the wall distance
      if (needStepX) begin
        o_mapCol <= i_stepXPositive ? o_mapCol + 1'b1 : o_mapCol - 1'b1;
        trackX <= trackX + fixedPointPkg::uFixedT'(i_stepDistX);
        o_wallDist <= trackX[fixedPointPkg::fracBits+6:fixedPointPkg::fracBits-9];
        o_hitSide <= 1'b0;
      end else begin
        o_mapRow <= i_stepYPositive ? o_mapRow + 1'b1 : o_mapRow - 1'b1;
        trackY <= trackY + fixedPointPkg::uFixedT'(i_stepDistY);
        o_wallDist <= trackY[fixedPointPkg::fracBits+6:fixedPointPkg::fracBits-9];
        o_hitSide <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/wallSizer.sv
`default_nettype none

module wallSizer (
  input  wire logic                clk,
  input  wire logic                do_reset,
  input  wire logic                i_vsync,
  input  wire logic                i_hmax,
  input  wire logic                i_start,
  input  wire fixedPointPkg::distT i_wallDist,
  input  wire logic                i_hitSide,
  output fixedPointPkg::sizeT      o_size,
  output logic                     o_side,
  output logic                     o_present
);

  tracerPkg::sizerStateT state;
  logic                  frameReset;
  logic                  recipStart;
  logic                  recipDone;
  logic                  ready;
  logic                  sideHeld;
  fixedPointPkg::fixedT  recipValue;
  fixedPointPkg::fixedT  recipResult;

  // vsync idles the sizer but keeps the last presented result
  assign frameReset = do_reset || i_vsync;
  assign recipStart = (state == tracerPkg::sizerIdle) && i_start;

  // UQ7.9 distance placed back at bits 6 down to -9
  assign recipValue = {{(fixedPointPkg::intBits-7){1'b0}}, i_wallDist,
                       {(fixedPointPkg::fracBits-9){1'b0}}};

  // The result can be taken in the cycle the divider finishes
  assign ready = (state == tracerPkg::sizerHold)
              || ((state == tracerPkg::sizerDivide) && recipDone);

  reciprocal sizeRecip (
    .clk      (clk),
    .do_reset (frameReset),
    .i_start  (recipStart),
    .i_value  (recipValue),
    .o_done   (recipDone),
    .o_result (recipResult)
  );

  always_ff @(posedge clk) begin
    if (frameReset) begin
      state <= tracerPkg::sizerIdle;
      o_present <= 1'b0;
      if (do_reset) begin
        o_size <= '0;
        o_side <= 1'b0;
      end
    end else begin
      o_present <= 1'b0;
      case (state)
        tracerPkg::sizerIdle: begin
          if (i_start) begin
            state <= tracerPkg::sizerDivide;
            sideHeld <= i_hitSide;
          end
        end
        tracerPkg::sizerDivide: if (recipDone) state <= tracerPkg::sizerHold;
        default: ;
      endcase
      // Present on hmax and free the chain for the next row
      if (ready && i_hmax) begin
        state <= tracerPkg::sizerIdle;
        o_size <= recipResult[fixedPointPkg::fracBits+2:fixedPointPkg::fracBits-8];
        o_side <= sideHeld;
        o_present <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/wallTracer.sv
`default_nettype none

module wallTracer (
  input  wire logic                 clk,
  input  wire logic                 do_reset,
  input  wire logic                 i_vsync,
  input  wire logic                 i_hmax,
  input  wire fixedPointPkg::fixedT i_playerX,
  input  wire fixedPointPkg::fixedT i_playerY,
  input  wire fixedPointPkg::fixedT i_facingX,
  input  wire fixedPointPkg::fixedT i_facingY,
  input  wire fixedPointPkg::fixedT i_vplaneX,
  input  wire fixedPointPkg::fixedT i_vplaneY,
  output tracerPkg::mapCoordT       o_mapCol,
  output tracerPkg::mapCoordT       o_mapRow,
  input  wire logic                 i_mapVal,
  output fixedPointPkg::sizeT       o_size,
  output logic                      o_side
);

  // Setup and walker restart on vsync as well as on reset
  logic                  frameReset;
  logic                  rowStart;
  fixedPointPkg::fixedT  rayDirX;
  fixedPointPkg::fixedT  rayDirY;
  logic                  setupDone;
  fixedPointPkg::fixedT  stepDistX;
  fixedPointPkg::fixedT  stepDistY;
  fixedPointPkg::uFixedT trackInitX;
  fixedPointPkg::uFixedT trackInitY;
  logic                  stepXPositive;
  logic                  stepYPositive;
  logic                  walkDone;
  fixedPointPkg::distT   wallDist;
  logic                  hitSide;
  logic                  present;

  assign frameReset = do_reset || i_vsync;

  rayGenerator rayGen (
    .clk        (clk),
    .do_reset   (do_reset),
    .i_vsync    (i_vsync),
    .i_present  (present),
    .i_facingX  (i_facingX),
    .i_facingY  (i_facingY),
    .i_vplaneX  (i_vplaneX),
    .i_vplaneY  (i_vplaneY),
    .o_rowStart (rowStart),
    .o_rayDirX  (rayDirX),
    .o_rayDirY  (rayDirY)
  );

  stepSetup setup (
    .clk             (clk),
    .do_reset        (frameReset),
    .i_start         (rowStart),
    .i_rayDirX       (rayDirX),
    .i_rayDirY       (rayDirY),
    .i_playerX       (i_playerX),
    .i_playerY       (i_playerY),
    .o_done          (setupDone),
    .o_stepDistX     (stepDistX),
    .o_stepDistY     (stepDistY),
    .o_trackInitX    (trackInitX),
    .o_trackInitY    (trackInitY),
    .o_stepXPositive (stepXPositive),
    .o_stepYPositive (stepYPositive)
  );

  gridWalker walker (
    .clk             (clk),
    .do_reset        (frameReset),
    .i_start         (setupDone),
    .i_playerX       (i_playerX),
    .i_playerY       (i_playerY),
    .i_stepDistX     (stepDistX),
    .i_stepDistY     (stepDistY),
    .i_trackInitX    (trackInitX),
    .i_trackInitY    (trackInitY),
    .i_stepXPositive (stepXPositive),
    .i_stepYPositive (stepYPositive),
    .i_mapVal        (i_mapVal),
    .o_mapCol        (o_mapCol),
    .o_mapRow        (o_mapRow),
    .o_done          (walkDone),
    .o_wallDist      (wallDist),
    .o_hitSide       (hitSide)
  );

  wallSizer sizer (
    .clk        (clk),
    .do_reset   (do_reset),
    .i_vsync    (i_vsync),
    .i_hmax     (i_hmax),
    .i_start    (walkDone),
    .i_wallDist (wallDist),
    .i_hitSide  (hitSide),
    .o_size     (o_size),
    .o_side     (o_side),
    .o_present  (present)
  );

endmodule

`default_nettype wire

//--- verif/wallTracerTb.sv
`default_nettype none

module wallTracerTb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk;
  logic                  do_reset;
  logic                  vsync;
  logic                  hmax;
  fixedPointPkg::fixedT  playerX;
  fixedPointPkg::fixedT  playerY;
  fixedPointPkg::fixedT  facingX;
  fixedPointPkg::fixedT  facingY;
  fixedPointPkg::fixedT  vplaneX;
  fixedPointPkg::fixedT  vplaneY;
  tracerPkg::mapCoordT   mapCol;
  tracerPkg::mapCoordT   mapRow;
  logic                  mapVal;
  fixedPointPkg::sizeT   size;
  logic                  side;

  // One word of the vector file per hex token
  logic [23:0]           vec [0:127];
  // One word per map row where bit c is column c
  logic [15:0]           mapRows [0:15];
  logic [31:0]           lfsrState;
  int                    cycles;
  int                    cycleLimit;

  wallTracer DUT (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_vsync   (vsync),
    .i_hmax    (hmax),
    .i_playerX (playerX),
    .i_playerY (playerY),
    .i_facingX (facingX),
    .i_facingY (facingY),
    .i_vplaneX (vplaneX),
    .i_vplaneY (vplaneY),
    .o_mapCol  (mapCol),
    .o_mapRow  (mapRow),
    .i_mapVal  (mapVal),
    .o_size    (size),
    .o_side    (side)
  );

  // The map answers in the same cycle and a set bit is a wall
  assign mapVal = mapRows[mapRow][mapCol];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compareSize(input string name, input fixedPointPkg::sizeT actual,
                             input fixedPointPkg::sizeT expected);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, actual, expected));
    end
  endtask

  task automatic compareSide(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch at %0t: %s got %b expected %b",
                              $time, name, actual, expected));
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Eight fresh bits with one register step per bit
  task automatic randomByte(output int value);
    logic [7:0] bits;
    bits = '0;
    for (int i = 0; i < 8; i++) begin
      lfsrState = nextLfsr(lfsrState);
      bits = {bits[6:0], lfsrState[0]};
    end
    value = int'(bits);
  endtask

  // The watchdog limit comes from the number of rows in the vector file
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      reportFailure($sformatf("timeout after %0d cycles, the DUT stopped presenting rows",
                              cycles));
    end
  end

  initial begin
    int frameCount;
    int totalRows;
    int ptr;
    int rows;
    int gap;
    fixedPointPkg::sizeT heldSize;
    logic                heldSide;
    fixedPointPkg::sizeT expSize;
    logic                expSide;

    do_reset = 1'b1;
    vsync = 1'b0;
    hmax = 1'b0;
    playerX = '0;
    playerY = '0;
    facingX = '0;
    facingY = '0;
    vplaneX = '0;
    vplaneY = '0;
    cycles = 0;
    lfsrState = 32'h639a_c138;

    $readmemh("verif/traceInput.txt", vec);
    for (int i = 0; i < 16; i++) begin
      mapRows[i] = vec[i][15:0];
    end
    frameCount = int'(vec[16]);

    // Walk the frame records once to size the watchdog
    totalRows = 0;
    ptr = 17;
    for (int f = 0; f < frameCount; f++) begin
      rows = int'(vec[ptr + 6]);
      totalRows = totalRows + rows;
      ptr = ptr + 7 + 2 * rows;
    end
    cycleLimit = totalRows * 600 + 1000;

    repeat (2) @(negedge clk);
    do_reset = 1'b0;

    // Nothing has been presented yet
    heldSize = '0;
    heldSide = 1'b0;
    compareSize("o_size", size, heldSize);
    compareSide("o_side", side, heldSide);

    ptr = 17;
    for (int f = 0; f < frameCount; f++) begin
      // New camera goes in with vsync, which also restarts at the top row
      @(negedge clk);
      playerX = vec[ptr];
      playerY = vec[ptr + 1];
      facingX = vec[ptr + 2];
      facingY = vec[ptr + 3];
      vplaneX = vec[ptr + 4];
      vplaneY = vec[ptr + 5];
      vsync = 1'b1;
      @(negedge clk);
      vsync = 1'b0;
      rows = int'(vec[ptr + 6]);
      ptr = ptr + 7;

      for (int r = 0; r < rows; r++) begin
        randomByte(gap);
        gap = gap + 300;
        // The outputs keep the last result while the next row is traced
        repeat (gap) begin
          @(negedge clk);
          compareSize("o_size", size, heldSize);
          compareSide("o_side", side, heldSide);
        end
        hmax = 1'b1;
        @(negedge clk);
        hmax = 1'b0;
        expSize = vec[ptr][10:0];
        expSide = vec[ptr + 1][0];
        ptr = ptr + 2;
        compareSize("o_size", size, expSize);
        compareSide("o_side", side, expSide);
        heldSize = expSize;
        heldSide = expSide;
      end
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/traceInput.txt
// Map rows 0 to 15 in hex, bit c is column c; then the number of frames
// Per frame: playerX playerY facingX facingY vplaneX vplaneY, row count, then size side per row
FFFF 8001 8001 8001
8001 8001 8001 9101
8001 9001 8001 8001
8001 8001 8001 FFFF
4
// Corridor view straight along +X, every row hits the far wall at 12.5
002800 008800 001000 000000 000000 000000
2
014 0
014 0
// Sweep of the Y direction, cut short by vsync after three rows
004800 008800 000400 004380 000000 004000
3
010 1
008 1
006 0
// Same camera again from the top row, through zero and positive Y
004800 008800 000400 004380 000000 004000
5
010 1
008 1
006 0
008 1
008 0
// Player on a cell edge facing the wall, the reciprocal saturates
001000 008800 FFF000 000000 000000 000000
1
7FF 0

//--- project.f
hdl/fixedPointPkg.sv
hdl/tracerPkg.sv
hdl/reciprocal.sv
hdl/rayGenerator.sv
hdl/stepSetup.sv
hdl/gridWalker.sv
hdl/wallSizer.sv
hdl/wallTracer.sv
verif/wallTracerTb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -f project.f --top-module wallTracerTb -o simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -f project.f --top-module wallTracerTb

clean:
	rm -rf obj_dir
